// File: source/i2c_bus_pkg.sv
/*
 * two-wire bus definitions: step timing, byte size and the
 * control byte with its field view
 */
package i2c_bus_pkg;

    // clk cycles between two step strobes
    // two steps per scl level, four per scl period
    localparam int STEP_CYCLES = 32;

    // bits moved per byte on sda, msb first
    localparam int BITS_PER_BYTE = 8;

    // fixed device type code of the serial eeprom family
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // control byte, sent right after a start or repeated start
    // raw view is what goes out on sda
    // field view is how the byte is built and decoded
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            // device type, upper nibble
            logic [3:0] device;
            // chip select pins a2..a0
            logic [2:0] chip_sel;
            // 1 for read, 0 for write
            logic       rw;
        } f;
    } ctrl_byte_u;

endpackage

// File: source/eeprom_txn_pkg.sv
/*
 * transaction constants and sequencer states for the key-driven
 * random write and random read
 */
package eeprom_txn_pkg;

    // word address used by both transactions
    localparam logic [7:0] ADDR_HIGH = 8'h00;
    localparam logic [7:0] ADDR_LOW  = 8'h03;

    // data byte stored by a write request
    localparam logic [7:0] WRITE_DATA = 8'h2F;

    // every ack state follows its send state directly
    typedef enum logic [4:0] {
        idle,
        start,
        send_ctrl_w,
        ack_ctrl_w,
        send_addr_hi,
        ack_addr_hi,
        send_addr_lo,
        ack_addr_lo,
        send_data,
        ack_data,
        stop_write,
        restart,
        send_ctrl_r,
        ack_ctrl_r,
        recv_data,
        load_result,
        send_nack,
        stop_read
    } seq_state_e;

endpackage

// File: source/scl_timer.sv
/*
 * scl timer: step strobe every STEP_CYCLES clk and scl toggling
 * every second step while a transaction runs
 */
`timescale 1ns/1ns

module scl_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic busy,
    output logic step,
    output logic scl
);

    // free running divider, wraps once per step
    logic [4:0] step_cnt;
    // low on the first step of an scl level, high on the second
    logic       phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 5'd1;
        end
    end

    // one clk pulse at the end of every divider period
    assign step = (step_cnt == 5'(i2c_bus_pkg::STEP_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl   <= 1'b1;
            phase <= 1'b0;
        end else if (step) begin
            if (!busy) begin
                // bus idle, clock parked high
                scl   <= 1'b1;
                phase <= 1'b0;
            end else begin
                phase <= ~phase;
                // level ends after two steps
                if (phase) begin
                    scl <= ~scl;
                end
            end
        end
    end

endmodule

// File: source/key_request.sv
/*
 * request latches for the active-low write and read keys,
 * held until the sequencer clears them
 */
`timescale 1ns/1ns

module key_request (
    input  logic clk,
    input  logic rst_n,
    input  logic key_wr,
    input  logic key_rd,
    input  logic clr_wr,
    input  logic clr_rd,
    output logic wr_req,
    output logic rd_req
);

    // clear wins over a key still held on the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_req <= 1'b0;
        end else if (clr_wr) begin
            wr_req <= 1'b0;
        end else if (!key_wr) begin
            wr_req <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_req <= 1'b0;
        end else if (clr_rd) begin
            rd_req <= 1'b0;
        end else if (!key_rd) begin
            rd_req <= 1'b1;
        end
    end

endmodule

// File: source/byte_shifter.sv
/*
 * msb-first byte shift register and bit counter used for both
 * transmit and receive
 */
`timescale 1ns/1ns

module byte_shifter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic [7:0] load_value,
    input  logic       shift_en,
    input  logic       rx_mode,
    input  logic       rx_bit,
    output logic       tx_bit,
    output logic [7:0] rx_byte,
    output logic       byte_done
);

    logic [7:0] shreg;
    // counts shifts since the last load
    logic [3:0] bit_cnt;

    // shift data, loaded at the start of each byte
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= load_value;
        end else if (shift_en && !byte_done) begin
            // receive fills from the bus
            // transmit pads with zero
            shreg <= {shreg[6:0], rx_mode ? rx_bit : 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= '0;
        end else if (shift_en && !byte_done) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // current bit to put on sda
    assign tx_bit    = shreg[7];
    assign rx_byte   = shreg;
    // counter stops here until the next load
    assign byte_done = (bit_cnt == 4'(i2c_bus_pkg::BITS_PER_BYTE));

endmodule

// File: source/eeprom_sequencer.sv
/*
 * eeprom transaction FSM: random write and random read on the
 * two-wire bus, sda drive, read result and done led
 */
`timescale 1ns/1ns

module eeprom_sequencer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       step,
    input  logic       scl,
    input  logic       sda_in,
    input  logic       wr_req,
    input  logic       rd_req,
    input  logic       keys_released,
    input  logic       tx_bit,
    input  logic [7:0] rx_byte,
    input  logic       byte_done,
    output logic       load,
    output logic [7:0] load_value,
    output logic       shift_en,
    output logic       rx_mode,
    output logic       sda_oe,
    output logic       sda_out,
    output logic       clr_wr,
    output logic       clr_rd,
    output logic       busy,
    output logic [7:0] result,
    output logic       led
);

    eeprom_txn_pkg::seq_state_e state;
    i2c_bus_pkg::ctrl_byte_u    ctrl_byte;

    // scl level seen at the previous step
    logic scl_q;
    // step in the middle of an scl level, scl settled
    logic mid;
    logic mid_lo;
    logic mid_hi;
    // slave pulled sda low while scl high
    logic acked;
    logic sending;

    // scl changes on the step after a mid step
    assign mid    = step && (scl != scl_q);
    assign mid_lo = mid && !scl;
    assign mid_hi = mid && scl;
    assign acked  = mid_hi && !sda_in;

    assign busy    = (state != eeprom_txn_pkg::idle);
    assign rx_mode = (state == eeprom_txn_pkg::recv_data);
    assign sending = state inside {eeprom_txn_pkg::send_ctrl_w,
                                   eeprom_txn_pkg::send_addr_hi,
                                   eeprom_txn_pkg::send_addr_lo,
                                   eeprom_txn_pkg::send_data,
                                   eeprom_txn_pkg::send_ctrl_r};

    // transmit moves a bit while scl low, receive samples while high
    assign shift_en = ((sending && mid_lo) || (rx_mode && mid_hi)) && !byte_done;

    // control byte through its fields
    // read flag only for the byte after the repeated start
    always_comb begin
        ctrl_byte.f.device   = i2c_bus_pkg::DEVICE_CODE;
        ctrl_byte.f.chip_sel = 3'b000;
        ctrl_byte.f.rw       = (state == eeprom_txn_pkg::restart);
    end

    // next byte goes into the shifter as the state moves on
    always_comb begin
        load       = 1'b0;
        load_value = 8'h00;
        case (state)
            eeprom_txn_pkg::start,
            eeprom_txn_pkg::restart: begin
                load       = mid_hi;
                load_value = ctrl_byte.raw;
            end
            eeprom_txn_pkg::ack_ctrl_w: begin
                load       = acked;
                load_value = eeprom_txn_pkg::ADDR_HIGH;
            end
            eeprom_txn_pkg::ack_addr_hi: begin
                load       = acked;
                load_value = eeprom_txn_pkg::ADDR_LOW;
            end
            eeprom_txn_pkg::ack_addr_lo: begin
                // read path loads in restart instead
                load       = acked && wr_req;
                load_value = eeprom_txn_pkg::WRITE_DATA;
            end
            // only clears the bit counter before receiving
            eeprom_txn_pkg::ack_ctrl_r: load = acked;
            default: load = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= eeprom_txn_pkg::idle;
            scl_q   <= 1'b1;
            sda_oe  <= 1'b1;
            sda_out <= 1'b1;
            clr_wr  <= 1'b0;
            clr_rd  <= 1'b0;
            result  <= 8'h00;
            led     <= 1'b1;
        end else begin
            // clears are single clk pulses
            clr_wr <= 1'b0;
            clr_rd <= 1'b0;
            if (step) begin
                scl_q <= scl;
            end
            case (state)
                eeprom_txn_pkg::idle: begin
                    // own the bus and hold it high
                    sda_oe  <= 1'b1;
                    sda_out <= 1'b1;
                    if (step && scl && (wr_req || rd_req)) begin
                        state <= eeprom_txn_pkg::start;
                    end
                end
                eeprom_txn_pkg::start: begin
                    // sda falls while scl high
                    if (mid_hi) begin
                        sda_out <= 1'b0;
                        state   <= eeprom_txn_pkg::send_ctrl_w;
                    end
                end
                eeprom_txn_pkg::send_ctrl_w,
                eeprom_txn_pkg::send_addr_hi,
                eeprom_txn_pkg::send_addr_lo,
                eeprom_txn_pkg::send_data,
                eeprom_txn_pkg::send_ctrl_r: begin
                    if (mid_lo) begin
                        if (byte_done) begin
                            // let go of sda for the ack clock
                            sda_oe <= 1'b0;
                            state  <= state.next();
                        end else begin
                            sda_oe  <= 1'b1;
                            sda_out <= tx_bit;
                        end
                    end
                end
                // without an ack the FSM just keeps waiting
                eeprom_txn_pkg::ack_ctrl_w,
                eeprom_txn_pkg::ack_addr_hi,
                eeprom_txn_pkg::ack_data,
                eeprom_txn_pkg::ack_ctrl_r: begin
                    if (acked) begin
                        state <= state.next();
                    end
                end
                eeprom_txn_pkg::ack_addr_lo: begin
                    // write request wins if both keys were pressed
                    if (acked) begin
                        state <= wr_req ? eeprom_txn_pkg::send_data
                                        : eeprom_txn_pkg::restart;
                    end
                end
                eeprom_txn_pkg::stop_write: begin
                    // stop repeats every scl period while a key is held
                    if (mid_lo) begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    if (mid_hi) begin
                        sda_out <= 1'b1;
                        if (keys_released) begin
                            clr_wr <= 1'b1;
                            state  <= eeprom_txn_pkg::idle;
                        end
                    end
                end
                eeprom_txn_pkg::restart: begin
                    // sda high during scl low, then falls while high
                    if (mid_lo) begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;
                    end
                    if (mid_hi) begin
                        sda_out <= 1'b0;
                        state   <= eeprom_txn_pkg::send_ctrl_r;
                    end
                end
                eeprom_txn_pkg::recv_data: begin
                    // byte in, take the bus back with sda high
                    if (mid_lo && byte_done) begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;
                        state   <= eeprom_txn_pkg::load_result;
                    end
                end
                eeprom_txn_pkg::load_result: begin
                    // single clk, before the nack clock goes high
                    result <= rx_byte;
                    state  <= eeprom_txn_pkg::send_nack;
                end
                eeprom_txn_pkg::send_nack: begin
                    // sda stays high through the ninth clock
                    if (mid_hi) begin
                        state <= eeprom_txn_pkg::stop_read;
                    end
                end
                eeprom_txn_pkg::stop_read: begin
                    if (mid_lo) begin
                        sda_out <= 1'b0;
                    end
                    if (mid_hi) begin
                        sda_out <= 1'b1;
                        clr_rd  <= 1'b1;
                        // led on for good once a read is done
                        led     <= 1'b0;
                        state   <= eeprom_txn_pkg::idle;
                    end
                end
                default: state <= eeprom_txn_pkg::idle;
            endcase
        end
    end

endmodule

// File: source/eeprom_key_ctrl.sv
/*
 * key-driven serial eeprom controller, top level with the
 * open-drain style sda driver
 */
`timescale 1ns/1ns

module eeprom_key_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_wr,
    input  logic       key_rd,
    output logic       scl,
    inout  wire        sda,
    output logic       led,
    output logic [7:0] result
);

    logic       step;
    logic       busy;
    logic       wr_req;
    logic       rd_req;
    logic       clr_wr;
    logic       clr_rd;
    logic       keys_released;
    logic       sda_oe;
    logic       sda_out;
    logic       sda_in;
    logic       load;
    logic [7:0] load_value;
    logic       shift_en;
    logic       rx_mode;
    logic       tx_bit;
    logic [7:0] rx_byte;
    logic       byte_done;

    // bus released when the FSM is not driving
    assign sda    = sda_oe ? sda_out : 1'bz;
    assign sda_in = sda;

    // both keys up, active low
    assign keys_released = key_wr & key_rd;

    scl_timer scl_timer_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .busy (busy),
        .step (step),
        .scl  (scl)
    );

    key_request key_request_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .key_wr(key_wr),
        .key_rd(key_rd),
        .clr_wr(clr_wr),
        .clr_rd(clr_rd),
        .wr_req(wr_req),
        .rd_req(rd_req)
    );

    byte_shifter byte_shifter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .load_value(load_value),
        .shift_en  (shift_en),
        .rx_mode   (rx_mode),
        .rx_bit    (sda_in),
        .tx_bit    (tx_bit),
        .rx_byte   (rx_byte),
        .byte_done (byte_done)
    );

    eeprom_sequencer eeprom_sequencer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .step         (step),
        .scl          (scl),
        .sda_in       (sda_in),
        .wr_req       (wr_req),
        .rd_req       (rd_req),
        .keys_released(keys_released),
        .tx_bit       (tx_bit),
        .rx_byte      (rx_byte),
        .byte_done    (byte_done),
        .load         (load),
        .load_value   (load_value),
        .shift_en     (shift_en),
        .rx_mode      (rx_mode),
        .sda_oe       (sda_oe),
        .sda_out      (sda_out),
        .clr_wr       (clr_wr),
        .clr_rd       (clr_rd),
        .busy         (busy),
        .result       (result),
        .led          (led)
    );

endmodule

// File: bench/eeprom_model.sv
/*
 * behavioral serial eeprom slave that detects start and stop, acks every
 * byte sent to it, stores write data and returns data on a read
 */
`timescale 1ns/1ns

module eeprom_model (
    input  logic scl,
    inout  wire  sda
);

    // own sda changes land 1.5 steps after scl falls and after the master let go
    localparam int DRIVE_DELAY = i2c_bus_pkg::STEP_CYCLES * 12;

    logic [7:0]  mem [0:65535];
    logic        drv_low;
    logic        active;
    logic        reading;
    logic        rd_pending;
    logic        ack_next;
    logic [3:0]  bit_cnt;
    int          byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  rd_data;
    logic [15:0] addr;
    i2c_bus_pkg::ctrl_byte_u ctrl;

    // seen by the testbench
    logic [7:0]  last_ctrl_w;
    logic [7:0]  last_ctrl_r;
    logic [15:0] last_addr;
    int          write_count;
    int          read_count;

    // open drain that only ever pulls low
    assign sda = drv_low ? 1'b0 : 1'bz;

    initial begin
        drv_low     = 1'b0;
        active      = 1'b0;
        reading     = 1'b0;
        rd_pending  = 1'b0;
        ack_next    = 1'b0;
        bit_cnt     = 4'd0;
        byte_idx    = 0;
        shreg       = 8'h00;
        rd_data     = 8'h00;
        addr        = 16'h0000;
        last_ctrl_w = 8'h00;
        last_ctrl_r = 8'h00;
        last_addr   = 16'h0000;
        write_count = 0;
        read_count  = 0;
        // content depends on both address bytes
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5c;
        end
    end

    task automatic preload(input logic [15:0] a, input logic [7:0] d);
        mem[a] = d;
    endtask

    // forget the control bytes and address of earlier transactions
    task automatic clear_seen();
        last_ctrl_w = 8'h00;
        last_ctrl_r = 8'h00;
        last_addr   = 16'h0000;
    endtask

    // byte just completed in write direction
    task automatic take_byte();
        ack_next = 1'b1;
        case (byte_idx)
            0: begin
                ctrl.raw = shreg;
                if (ctrl.f.device != i2c_bus_pkg::DEVICE_CODE) begin
                    // no ack for another device
                    ack_next = 1'b0;
                    active   = 1'b0;
                end else if (ctrl.f.rw) begin
                    last_ctrl_r = shreg;
                    rd_pending  = 1'b1;
                    rd_data     = mem[addr];
                end else begin
                    last_ctrl_w = shreg;
                end
            end
            1: addr[15:8] = shreg;
            2: begin
                addr[7:0] = shreg;
                last_addr = addr;
            end
            default: begin
                mem[addr]   = shreg;
                addr        = addr + 16'd1;
                write_count = write_count + 1;
            end
        endcase
    endtask

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active     = 1'b1;
            bit_cnt    = 4'd0;
            byte_idx   = 0;
            reading    = 1'b0;
            rd_pending = 1'b0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bit_cnt < 4'd8) begin
                if (!reading) begin
                    shreg = {shreg[6:0], (sda === 1'b1)};
                end
                bit_cnt = bit_cnt + 4'd1;
                if (bit_cnt == 4'd8 && !reading) begin
                    take_byte();
                end
            end else begin
                // ninth clock carries the ack or nack
                bit_cnt  = 4'd0;
                byte_idx = byte_idx + 1;
                if (reading) begin
                    read_count = read_count + 1;
                    addr       = addr + 16'd1;
                    rd_data    = mem[addr];
                    // master nack ends the read
                    if (sda === 1'b1) begin
                        active = 1'b0;
                    end
                end
                if (rd_pending) begin
                    reading    = 1'b1;
                    rd_pending = 1'b0;
                end
            end
        end
    end

    always @(negedge scl) begin
        drv_low = 1'b0;
        if (active) begin
            if (!reading && bit_cnt == 4'd8 && ack_next) begin
                drv_low <= #DRIVE_DELAY 1'b1;
            end else if (reading && bit_cnt < 4'd8) begin
                drv_low <= #DRIVE_DELAY !rd_data[3'(7 - bit_cnt)];
            end
        end
    end

endmodule

// File: bench/tb_eeprom_key_ctrl.sv
/*
 * testbench for the key-driven eeprom controller that runs the tests
 * listed in the stimulus file against the eeprom model
 */
`timescale 1ns/1ns

module tb_eeprom_key_ctrl;

    localparam int WAIT_LIMIT  = 20000;
    // longer than any scl high level inside a transaction
    localparam int IDLE_HIGH   = i2c_bus_pkg::STEP_CYCLES * 5;
    // longer than a whole write transaction
    localparam int HOLD_CYCLES = i2c_bus_pkg::STEP_CYCLES * 200;

    logic       clk;
    logic       rst_n;
    logic       key_wr;
    logic       key_rd;
    logic       scl;
    logic       led;
    logic [7:0] result;
    wire        sda;

    int         errors;
    int         tests;
    bit         aborted;
    // led goes low for good once a read has finished
    logic       led_exp;

    // bus pull-up
    pullup (sda);

    eeprom_key_ctrl eeprom_key_ctrl_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .key_wr(key_wr),
        .key_rd(key_rd),
        .scl   (scl),
        .sda   (sda),
        .led   (led),
        .result(result)
    );

    eeprom_model eeprom_model_inst (
        .scl(scl),
        .sda(sda)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t: %s did not happen within %0d cycles", $time, what,
                 WAIT_LIMIT);
        aborted = 1'b1;
    endtask

    // transaction has begun once scl goes low
    task automatic wait_scl_low(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk);
            if (scl === 1'b0) ok = 1'b1;
        end
        if (!ok) stop_on_timeout("scl toggling");
    endtask

    task automatic wait_bus_idle(output bit ok);
        int n;
        int high_run;
        ok = 1'b0;
        high_run = 0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk);
            high_run = (scl === 1'b1) ? high_run + 1 : 0;
            if (high_run >= IDLE_HIGH) ok = 1'b1;
        end
        if (!ok) stop_on_timeout("return to idle");
    endtask

    task automatic wait_writes(input int target, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk);
            if (eeprom_model_inst.write_count >= target) ok = 1'b1;
        end
        if (!ok) stop_on_timeout("data byte written to the eeprom");
    endtask

    task automatic wait_reads(input int target, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk);
            if (eeprom_model_inst.read_count >= target) ok = 1'b1;
        end
        if (!ok) stop_on_timeout("data byte read from the eeprom");
    endtask

    task automatic run_write(input logic [7:0] expected);
        int cnt0;
        bit ok;
        cnt0 = eeprom_model_inst.write_count;
        @(posedge clk);
        key_wr <= 1'b0;
        repeat (4) @(posedge clk);
        key_wr <= 1'b1;
        wait_scl_low(ok);
        if (!ok) return;
        wait_writes(cnt0 + 1, ok);
        if (!ok) return;
        wait_bus_idle(ok);
        if (!ok) return;
        check("ctrl_w", 16'h00a0, {8'h00, eeprom_model_inst.last_ctrl_w});
        check("addr", 16'h0003, eeprom_model_inst.last_addr);
        check("mem_0003", {8'h00, expected}, {8'h00, eeprom_model_inst.mem[16'h0003]});
        check("write_count", 16'(cnt0 + 1), 16'(eeprom_model_inst.write_count));
        check("led", {15'd0, led_exp}, {15'd0, led});
    endtask

    task automatic run_read(input logic [7:0] expected);
        int cnt0;
        bit ok;
        cnt0 = eeprom_model_inst.read_count;
        @(posedge clk);
        key_rd <= 1'b0;
        repeat (4) @(posedge clk);
        key_rd <= 1'b1;
        wait_scl_low(ok);
        if (!ok) return;
        wait_reads(cnt0 + 1, ok);
        if (!ok) return;
        wait_bus_idle(ok);
        if (!ok) return;
        check("ctrl_w", 16'h00a0, {8'h00, eeprom_model_inst.last_ctrl_w});
        check("addr", 16'h0003, eeprom_model_inst.last_addr);
        check("ctrl_r", 16'h00a1, {8'h00, eeprom_model_inst.last_ctrl_r});
        check("result", {8'h00, expected}, {8'h00, result});
        check("led", 16'h0000, {15'd0, led});
        led_exp = 1'b0;
    endtask

    // key held through the write and only one data byte may reach the eeprom
    task automatic run_hold(input logic [7:0] expected);
        int cnt0;
        bit ok;
        bit saw_low;
        cnt0 = eeprom_model_inst.write_count;
        saw_low = 1'b0;
        @(posedge clk);
        key_wr <= 1'b0;
        wait_scl_low(ok);
        if (!ok) return;
        wait_writes(cnt0 + 1, ok);
        if (!ok) return;
        // let the first stop go by
        repeat (HOLD_CYCLES / 2) @(posedge clk);
        repeat (HOLD_CYCLES / 2) begin
            @(posedge clk);
            if (scl === 1'b0) saw_low = 1'b1;
        end
        check("write_count_held", 16'(cnt0 + 1), 16'(eeprom_model_inst.write_count));
        // still busy so scl keeps toggling
        check("scl_toggling_held", 16'h0001, {15'd0, saw_low});
        key_wr <= 1'b1;
        wait_bus_idle(ok);
        if (!ok) return;
        check("write_count", 16'(cnt0 + 1), 16'(eeprom_model_inst.write_count));
        check("mem_0003", {8'h00, expected}, {8'h00, eeprom_model_inst.mem[16'h0003]});
    endtask

    initial begin
        int         fd;
        int         errs_before;
        string      line;
        string      op;
        string      pre_s;
        logic [7:0] pre_v;
        logic [7:0] exp_v;
        rst_n   = 1'b0;
        key_wr  = 1'b1;
        key_rd  = 1'b1;
        errors  = 0;
        tests   = 0;
        aborted = 1'b0;
        led_exp = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // idle bus straight after reset
        errs_before = errors;
        check("scl", 16'h0001, {15'd0, scl});
        check("sda", 16'h0001, {15'd0, sda});
        check("led", 16'h0001, {15'd0, led});
        check("result", 16'h0000, {8'h00, result});
        tests++;
        $display("test %0d reset: %s", tests, (errors == errs_before) ? "ok" : "errors");

        fd = $fopen("bench/eeprom_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/eeprom_stimulus.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && !aborted) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") continue;
                if ($sscanf(line, "%s %s %h", op, pre_s, exp_v) != 3) continue;
                // a dash keeps what the eeprom already holds
                if (pre_s != "-" && $sscanf(pre_s, "%h", pre_v) == 1) begin
                    eeprom_model_inst.preload(16'h0003, pre_v);
                end
                eeprom_model_inst.clear_seen();
                errs_before = errors;
                case (op)
                    "w":     run_write(exp_v);
                    "r":     run_read(exp_v);
                    "hold":  run_hold(exp_v);
                    default: begin
                        $display("unknown operation %s in the stimulus file", op);
                        errors++;
                    end
                endcase
                tests++;
                $display("test %0d %s: %s", tests, op,
                         (errors == errs_before && !aborted) ? "ok" : "errors");
            end
            $fclose(fd);
        end

        $display("tests run %0d, errors %0d, aborted %0d", tests, errors, aborted);
        if (errors == 0 && !aborted) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sim.f
source/i2c_bus_pkg.sv
source/eeprom_txn_pkg.sv
source/scl_timer.sv
source/key_request.sv
source/byte_shifter.sv
source/eeprom_sequencer.sv
source/eeprom_key_ctrl.sv
bench/eeprom_model.sv
bench/tb_eeprom_key_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the eeprom key controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f sim.f --top-module tb_eeprom_key_ctrl \
    -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "Verification passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: bench/eeprom_stimulus.txt
# operation (w, r, hold)  preload byte at 0x0003 (- keeps memory)  expected byte
# w and hold expect the eeprom byte after the write, r expects result
w 00 2F
r - 2F
r 5A 5A
r C3 C3
r 00 00
r FF FF
w 7E 2F
r - 2F
hold 11 2F
r - 2F
r A5 A5
w - 2F
r - 2F
